// ==== flist.f ====
+incdir+dv
design/fifo_pkg.sv
design/ptr_counter.sv
design/fifo_ctrl.sv
design/fifo_storage.sv
design/fifo.sv
dv/fifo_tb.sv

// ==== Bender.yml ====
package:
  name: fifo

sources:
  - files:
      - design/fifo_pkg.sv
      - design/ptr_counter.sv
      - design/fifo_ctrl.sv
      - design/fifo_storage.sv
      - design/fifo.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/fifo_tb.sv

// ==== dv/fifo_ref.svh ====
`ifndef FIFO_REF_SVH
`define FIFO_REF_SVH

// expected buffer contents, oldest word at index 0
logic [fifo_width-1:0] model_q[$];

function automatic bit push_accepted(input logic push_req);
   return push_req && (model_q.size() < fifo_depth);
endfunction

function automatic bit pop_accepted(input logic pop_req);
   return pop_req && (model_q.size() > 0);
endfunction

function automatic logic expect_empty();
   return model_q.size() == 0;
endfunction

function automatic logic expect_full();
   return model_q.size() == fifo_depth;
endfunction

// push while full or pop while empty
function automatic logic expect_err(input logic push_req, input logic pop_req);
   return (push_req && model_q.size() == fifo_depth) || (pop_req && model_q.size() == 0);
endfunction

// output word is defined only with a stored word or a fall-through push
function automatic bit data_known(input logic push_req);
   return (model_q.size() > 0) || push_req;
endfunction

function automatic logic [fifo_width-1:0] expect_data(input logic push_req,
                                                      input logic [fifo_width-1:0] din);
   // empty with a push shows the pushed word
   if (model_q.size() == 0 && push_req) begin
      return din;
   end
   return model_q[0];
endfunction

// queue update at the clock edge
task automatic apply_request(input logic push_req, input logic pop_req,
                             input logic [fifo_width-1:0] din);
   bit do_push;
   bit do_pop;
   do_push = push_accepted(push_req);
   do_pop  = pop_accepted(pop_req);
   if (do_pop) begin
      void'(model_q.pop_front());
   end
   if (do_push) begin
      model_q.push_back(din);
   end
endtask

task automatic clear_model();
   model_q.delete();
endtask

`endif

// ==== dv/fifo_tb.sv ====
`timescale 1ns/1ps

module fifo_tb;

   localparam int fifo_width = 64;
   localparam int fifo_depth = 5;
   localparam int clk_half   = 50;
   // compare point, just before the next rising edge
   localparam int sample_ofs = 90;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  push;
   logic                  pop;
   logic [fifo_width-1:0] data_in;
   logic [fifo_width-1:0] data_out;
   logic                  empty;
   logic                  full;
   logic                  err;

   string test_name = "reset";
   int    error_count = 0;

   `include "fifo_ref.svh"

   fifo #(
      .WIDTH (fifo_width),
      .DEPTH (fifo_depth)
   ) UUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .push     (push),
      .data_in  (data_in),
      .pop      (pop),
      .data_out (data_out),
      .empty    (empty),
      .full     (full),
      .err      (err)
   );

   always #clk_half clk = ~clk;

   task automatic flag_check(input string what, input logic expected, input logic actual);
      assert (actual === expected) else begin
         error_count++;
         $display("error: test %s, %s expected %0b actual %0b",
                  test_name, what, expected, actual);
         $display("Finished with errors");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic word_check(input string what, input logic [fifo_width-1:0] expected,
                             input logic [fifo_width-1:0] actual);
      assert (actual === expected) else begin
         error_count++;
         $display("error: test %s, %s expected %h actual %h",
                  test_name, what, expected, actual);
         $display("Finished with errors");
         $fatal(1, "data mismatch");
      end
   endtask

   // one request per cycle, applied at the rising edge
   task automatic drive_cycle(input logic p, input logic q, input logic [fifo_width-1:0] d);
      @(posedge clk);
      push    <= p;
      pop     <= q;
      data_in <= d;
   endtask

   // bounded wait on full (want_full) or empty, sampled mid-cycle
   task automatic wait_for_flag(input bit want_full, input int max_cycles);
      bit seen;
      seen = 1'b0;
      for (int n = 0; n < max_cycles && !seen; n++) begin
         @(negedge clk);
         seen = want_full ? full : empty;
      end
      if (!seen) begin
         $display("timeout in test %s: %s flag not set within %0d cycles",
                  test_name, want_full ? "full" : "empty", max_cycles);
         $display("Finished with errors");
         $fatal(1, "wait timed out");
      end
   endtask

   // per-cycle comparison against the queue model
   always begin
      @(posedge clk);
      #sample_ofs;
      if (!rst_n) begin
         clear_model();
      end else begin
         flag_check("empty", expect_empty(), empty);
         flag_check("full", expect_full(), full);
         flag_check("err", expect_err(push, pop), err);
         if (data_known(push)) begin
            word_check("data_out", expect_data(push, data_in), data_out);
         end
         apply_request(push, pop, data_in);
      end
   end

   initial begin : stimulus
      logic [fifo_width-1:0] word;
      int                    push_pct;
      void'($urandom(32'hc4ec4c0c));
      rst_n   = 1'b0;
      push    = 1'b0;
      pop     = 1'b0;
      data_in = '0;

      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      wait_for_flag(1'b0, 4);

      test_name = "fill_and_reject";
      for (int i = 0; i < fifo_depth; i++) begin
         drive_cycle(1'b1, 1'b0, {32'ha5a50000 + i, $urandom()});
      end
      drive_cycle(1'b0, 1'b0, '0);
      wait_for_flag(1'b1, 4);
      // rejected word must never reach the output
      drive_cycle(1'b1, 1'b0, 64'hdead_beef_0bad_f00d);
      drive_cycle(1'b0, 1'b0, '0);

      test_name = "drain_in_order";
      for (int i = 0; i < fifo_depth; i++) begin
         drive_cycle(1'b0, 1'b1, '0);
      end
      drive_cycle(1'b0, 1'b0, '0);
      wait_for_flag(1'b0, 4);
      drive_cycle(1'b0, 1'b1, '0);
      drive_cycle(1'b0, 1'b0, '0);

      test_name = "fall_through";
      word = {$urandom(), $urandom()};
      drive_cycle(1'b1, 1'b0, word);
      drive_cycle(1'b0, 1'b1, '0);
      drive_cycle(1'b0, 1'b0, '0);
      wait_for_flag(1'b0, 4);
      // push with pop on empty, pop rejected and one word kept
      word = {$urandom(), $urandom()};
      drive_cycle(1'b1, 1'b1, word);
      drive_cycle(1'b0, 1'b0, '0);
      drive_cycle(1'b0, 1'b1, '0);
      drive_cycle(1'b0, 1'b0, '0);
      wait_for_flag(1'b0, 4);

      test_name = "random_traffic";
      for (int n = 0; n < 4000; n++) begin
         // alternate fill and drain bias so both flags are reached
         push_pct = ((n / 200) % 2 == 0) ? 70 : 30;
         drive_cycle($urandom_range(99) < push_pct,
                     $urandom_range(99) < (100 - push_pct),
                     {$urandom(), $urandom()});
      end
      for (int i = 0; i < fifo_depth; i++) begin
         drive_cycle(1'b0, 1'b1, '0);
      end
      drive_cycle(1'b0, 1'b0, '0);
      wait_for_flag(1'b0, 4);
      repeat (2) @(posedge clk);

      if (error_count == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         $display("Finished with errors");
         $fatal(1, "checks failed");
      end
   end

endmodule

// ==== design/fifo.sv ====
`timescale 1ns/1ps

module fifo import fifo_pkg::*; #(
   parameter int WIDTH = fifo_width_def,
   parameter int DEPTH = fifo_depth_def,
   localparam int PTR_W = $clog2(DEPTH)
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             push,
   input  logic [WIDTH-1:0] data_in,
   input  logic             pop,
   output logic [WIDTH-1:0] data_out,
   output logic             empty,
   output logic             full,
   output logic             err
);

   // pointers and their wrapped successors
   logic [PTR_W-1:0] read_ptr;
   logic [PTR_W-1:0] read_ptr_next;
   logic [PTR_W-1:0] write_ptr;
   logic [PTR_W-1:0] write_ptr_next;

   // accepted pop and push
   logic read_en;
   logic write_en;

   fifo_state_t state;

   ptr_counter #(
      .DEPTH (DEPTH)
   ) read_ptr_counter (
      .clk      (clk),
      .rst_n    (rst_n),
      .advance  (read_en),
      .ptr      (read_ptr),
      .ptr_next (read_ptr_next)
   );

   ptr_counter #(
      .DEPTH (DEPTH)
   ) write_ptr_counter (
      .clk      (clk),
      .rst_n    (rst_n),
      .advance  (write_en),
      .ptr      (write_ptr),
      .ptr_next (write_ptr_next)
   );

   // occupancy FSM, acceptance and error flag
   fifo_ctrl #(
      .DEPTH (DEPTH)
   ) ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .push           (push),
      .pop            (pop),
      .read_ptr       (read_ptr),
      .read_ptr_next  (read_ptr_next),
      .write_ptr      (write_ptr),
      .write_ptr_next (write_ptr_next),
      .read_en        (read_en),
      .write_en       (write_en),
      .state          (state),
      .empty          (empty),
      .full           (full),
      .err            (err)
   );

   // entries, read mux and fall-through
   fifo_storage #(
      .WIDTH (WIDTH),
      .DEPTH (DEPTH)
   ) storage (
      .clk       (clk),
      .rst_n     (rst_n),
      .data_in   (data_in),
      .write_en  (write_en),
      .write_ptr (write_ptr),
      .read_ptr  (read_ptr),
      .state     (state),
      .data_out  (data_out)
   );

endmodule

// ==== design/fifo_storage.sv ====
`timescale 1ns/1ps

module fifo_storage import fifo_pkg::*; #(
   parameter int WIDTH = fifo_width_def,
   parameter int DEPTH = fifo_depth_def,
   localparam int PTR_W = $clog2(DEPTH)
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [WIDTH-1:0] data_in,
   input  logic             write_en,
   input  logic [PTR_W-1:0] write_ptr,
   input  logic [PTR_W-1:0] read_ptr,
   input  fifo_state_t      state,
   output logic [WIDTH-1:0] data_out
);

   logic [WIDTH-1:0] entry [DEPTH];

   // one-hot write select from the write pointer
   logic [DEPTH-1:0] write_sel;

   // word at the read pointer
   logic [WIDTH-1:0] read_word;

   // fall-through of a push into an empty buffer
   logic bypass;

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         write_sel[i] = write_en && (write_ptr == PTR_W'(i));
      end
   end

   // only the selected entry loads
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (write_sel[i]) begin
            entry[i] <= data_in;
         end
      end
   end

   // read mux over the entries
   always_comb begin
      read_word = entry[0];
      for (int i = 1; i < DEPTH; i++) begin
         if (read_ptr == PTR_W'(i)) begin
            read_word = entry[i];
         end
      end
   end

   assign bypass = (state == st_empty) && write_en;

   assign data_out = bypass ? data_in : read_word;

   // the word that fell through is still shown once it is stored
   a_bypass_kept : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == st_empty && write_en) |=> (data_out == $past(data_in))
   ) else $error("fifo_storage: fall-through word lost after write");

   // a write never overwrites the entry being read while words are held
   a_no_overwrite_head : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == st_partial && write_en) |-> (write_ptr != read_ptr)
   ) else $error("fifo_storage: write hit the oldest entry");

endmodule

// ==== design/fifo_ctrl.sv ====
`timescale 1ns/1ps

module fifo_ctrl import fifo_pkg::*; #(
   parameter int DEPTH = fifo_depth_def,
   localparam int PTR_W = $clog2(DEPTH)
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             push,
   input  logic             pop,
   input  logic [PTR_W-1:0] read_ptr,
   input  logic [PTR_W-1:0] read_ptr_next,
   input  logic [PTR_W-1:0] write_ptr,
   input  logic [PTR_W-1:0] write_ptr_next,
   output logic             read_en,
   output logic             write_en,
   output fifo_state_t      state,
   output logic             empty,
   output logic             full,
   output logic             err
);

   fifo_state_t state_next;

   // a push alone or a pop alone changes the occupancy
   logic push_only;
   logic pop_only;

   // the next write lands on the oldest word
   logic will_fill;
   // the next read catches up with the write pointer
   logic will_drain;

   // flags come straight from the state
   assign empty = (state == st_empty);
   assign full  = (state == st_full);

   // accepted requests
   assign write_en = push && !full;
   assign read_en  = pop && !empty;

   // illegal request, ignored by the datapath
   assign err = (push && full) || (pop && empty);

   assign push_only = write_en && !read_en;
   assign pop_only  = read_en && !write_en;

   assign will_fill  = (write_ptr_next == read_ptr);
   assign will_drain = (read_ptr_next == write_ptr);

   always_comb begin
      state_next = state;
      case (state)
         st_empty: begin
            // a pop is rejected here, so any accepted push leaves empty
            if (write_en) begin
               state_next = st_partial;
            end
         end
         st_partial: begin
            if (push_only && will_fill) begin
               state_next = st_full;
            end else if (pop_only && will_drain) begin
               state_next = st_empty;
            end
         end
         st_full: begin
            // push is rejected while full
            if (read_en) begin
               state_next = st_partial;
            end
         end
         default: begin
            state_next = st_empty;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_empty;
      end else begin
         state <= state_next;
      end
   end

   // no write may land on a stored word
   a_no_write_full : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == st_full) |-> !write_en
   ) else $error("fifo_ctrl: write accepted while full");

   // no read from an empty buffer
   a_no_read_empty : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == st_empty) |-> !read_en
   ) else $error("fifo_ctrl: read accepted while empty");

   a_flags_exclusive : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(empty && full)
   ) else $error("fifo_ctrl: empty and full both set");

   // pointers meet only when the buffer is empty or full
   a_ptr_meet : assert property (
      @(posedge clk) disable iff (!rst_n)
      (read_ptr == write_ptr) |-> (state != st_partial)
   ) else $error("fifo_ctrl: pointers equal in partial state");

endmodule

// ==== design/ptr_counter.sv ====
`timescale 1ns/1ps

module ptr_counter import fifo_pkg::*; #(
   parameter int DEPTH = fifo_depth_def,
   localparam int PTR_W = $clog2(DEPTH)
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             advance,
   output logic [PTR_W-1:0] ptr,
   output logic [PTR_W-1:0] ptr_next
);

   localparam logic [PTR_W-1:0] last_idx = PTR_W'(DEPTH - 1);

   // wrapped successor; depth may not be a power of two
   always_comb begin
      if (ptr == last_idx) begin
         ptr_next = '0;
      end else begin
         ptr_next = ptr + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (advance) begin
         ptr <= ptr_next;
      end
   end

   // pointer must stay inside the entry range
   a_ptr_in_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      ptr < DEPTH
   ) else $error("ptr_counter: pointer %0d out of range", ptr);

endmodule

// ==== design/fifo_pkg.sv ====
package fifo_pkg;

   // default word width
   localparam int fifo_width_def = 64;

   // default number of entries
   localparam int fifo_depth_def = 4;

   // occupancy state of the buffer
   //   st_empty   : no word stored
   //   st_partial : at least one word, at least one free entry
   //   st_full    : every entry holds a word
   typedef enum logic [1:0] {
      st_empty   = 2'b00,
      st_partial = 2'b01,
      st_full    = 2'b10
   } fifo_state_t;

endpackage
